/* hw/matmul_cfg.svh */
// SRAM address width, SRAM data width and matrix dimension field width
`ifndef MATMUL_CFG_SVH
`define MATMUL_CFG_SVH

//--------------------------------------------------------------------------
// SRAM ports
//--------------------------------------------------------------------------

// word address, same for input, weight and result SRAMs
`define SRAM_ADDR_WIDTH 16

// one data word, also one element of A, B or C
`define SRAM_DATA_WIDTH 32

//--------------------------------------------------------------------------
// header word
//--------------------------------------------------------------------------

// rows in the upper half of word 0, cols in the lower half
// two fields must fill exactly one data word
`define DIM_WIDTH 16

`endif

/* hw/matmul_pkg.sv */
// shared SRAM types, header word union and address command encoding
`include "matmul_cfg.svh"

package matmul_pkg;

	typedef logic [`SRAM_ADDR_WIDTH-1:0] sram_addr_t;
	typedef logic [`SRAM_DATA_WIDTH-1:0] sram_data_t;
	typedef logic [`DIM_WIDTH-1:0]       dim_t;

	// layout of word 0 in an operand SRAM
	typedef struct packed {
		dim_t rows; // upper half
		dim_t cols; // lower half
	} header_s;

	// word 0 read either as dimensions or as a raw word
	typedef union packed {
		header_s    hdr;
		sram_data_t word;
	} header_u;

	// address generator step for the next edge
	typedef enum logic [2:0] {
		cmd_hold     = 3'd0, // nothing issued, read pointers rest on word 0
		cmd_start    = 3'd1, // headers on the bus, go to first elements
		cmd_next_k   = 3'd2, // next term of the same dot product
		cmd_next_col = 3'd3, // same row of A, next column of B
		cmd_next_row = 3'd4  // next row of A, back to column 0 of B
	} addr_cmd_e;

endpackage

/* hw/matmul_ctrl.sv */
// job FSM, header decode, k/column/row counters and address commands
`timescale 1ns/1ns

module matmul_ctrl (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   dut_valid,
	output logic                   dut_ready,
	input  matmul_pkg::sram_data_t input_read_data,
	input  matmul_pkg::sram_data_t weight_read_data,
	output matmul_pkg::addr_cmd_e  addr_cmd,
	output logic                   issue,
	output logic                   first,
	output logic                   last
);
	import matmul_pkg::*;

	typedef enum logic [1:0] {
		st_idle   = 2'd0,
		st_header = 2'd1, // word 0 of both SRAMs on the read bus
		st_run    = 2'd2, // one product issued per cycle
		st_drain  = 2'd3  // last products still in the MAC
	} state_e;

	state_e  state;
	state_e  state_nxt;

	header_u in_hdr;
	header_u wt_hdr;

	// terminal counts, dimension minus one
	dim_t    row_max;
	dim_t    k_max;
	dim_t    col_max;

	dim_t    row_cnt;
	dim_t    k_cnt;
	dim_t    col_cnt;

	logic    k_end;
	logic    col_end;
	logic    row_end;
	logic    drain_cnt;

	assign in_hdr.word = input_read_data;
	assign wt_hdr.word = weight_read_data;

	assign k_end   = (k_cnt == k_max);
	assign col_end = (col_cnt == col_max);
	assign row_end = (row_cnt == row_max);

	assign issue = (state == st_run);
	assign first = issue && (k_cnt == '0);
	assign last  = issue && k_end;

	//----------------------------------------------------------------------
	// state machine
	//----------------------------------------------------------------------

	always_comb begin
		state_nxt = state;
		case (state)
			st_idle: begin
				if (dut_valid && dut_ready)
					state_nxt = st_header;
			end
			st_header: state_nxt = st_run;
			st_run: begin
				if (k_end && col_end && row_end)
					state_nxt = st_drain;
			end
			st_drain: begin
				if (drain_cnt) // second drain cycle, last write on the port
					state_nxt = st_idle;
			end
			default: state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state     <= st_idle;
			dut_ready <= 1'b0;
			drain_cnt <= 1'b0;
		end else begin
			state     <= state_nxt;
			dut_ready <= (state_nxt == st_idle); // low from acceptance to end of drain
			drain_cnt <= (state == st_drain) ? ~drain_cnt : 1'b0;
		end
	end

	// dimensions, taken once per job from the two headers
	// inner size follows B, A is trusted to match
	always_ff @(posedge clk) begin
		if (state == st_header) begin
			row_max <= in_hdr.hdr.rows - dim_t'(1);
			k_max   <= wt_hdr.hdr.rows - dim_t'(1);
			col_max <= wt_hdr.hdr.cols - dim_t'(1);
		end
	end

	//----------------------------------------------------------------------
	// element counters, k fastest then column then row
	//----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			k_cnt   <= '0;
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (state == st_header) begin
			k_cnt   <= '0;
			col_cnt <= '0;
			row_cnt <= '0;
		end else if (state == st_run) begin
			if (!k_end) begin
				k_cnt <= k_cnt + dim_t'(1);
			end else begin
				k_cnt <= '0;
				if (!col_end) begin
					col_cnt <= col_cnt + dim_t'(1);
				end else begin
					col_cnt <= '0;
					row_cnt <= row_cnt + dim_t'(1); // wraps after the last row, unused
				end
			end
		end
	end

	// address step for the read presented next cycle
	always_comb begin
		addr_cmd = cmd_hold;
		case (state)
			st_header: addr_cmd = cmd_start;
			st_run: begin
				if (!k_end)
					addr_cmd = cmd_next_k;
				else if (!col_end)
					addr_cmd = cmd_next_col;
				else if (!row_end)
					addr_cmd = cmd_next_row;
				else
					addr_cmd = cmd_hold; // final product of the job
			end
			default: addr_cmd = cmd_hold;
		endcase
	end

endmodule

/* hw/matmul_addr_gen.sv */
// A and B read pointers, B column stride and delayed C write address
`timescale 1ns/1ns
`include "matmul_cfg.svh"

module matmul_addr_gen (
	input  logic                   clk,
	input  logic                   reset_n,
	input  matmul_pkg::addr_cmd_e  addr_cmd,
	input  matmul_pkg::sram_data_t weight_read_data,
	output matmul_pkg::sram_addr_t input_read_address,
	output matmul_pkg::sram_addr_t weight_read_address,
	output matmul_pkg::sram_addr_t result_write_address
);
	import matmul_pkg::*;

	sram_addr_t a_base;   // first element of current A row
	sram_addr_t a_ptr;
	sram_addr_t b_col;    // top of current B column
	sram_addr_t b_ptr;
	sram_addr_t b_stride; // one B row, i.e. cols of B
	sram_addr_t c_ptr;
	logic [1:0] c_step;   // element boundary seen 1 and 2 cycles back

	assign input_read_address   = a_ptr;
	assign weight_read_address  = b_ptr;
	assign result_write_address = c_ptr;

	//----------------------------------------------------------------------
	// bases and stride
	//----------------------------------------------------------------------

	// weight header is on the bus while start is presented
	always_ff @(posedge clk) begin
		if (addr_cmd == cmd_start)
			b_stride <= sram_addr_t'(weight_read_data[`DIM_WIDTH-1:0]);
	end

	always_ff @(posedge clk) begin
		case (addr_cmd)
			cmd_start: begin
				a_base <= sram_addr_t'(1); // elements start after the header
				b_col  <= sram_addr_t'(1);
			end
			cmd_next_col: b_col <= b_col + 1'b1;
			cmd_next_row: begin
				a_base <= a_ptr + 1'b1; // a_ptr sits on the last k of the row
				b_col  <= sram_addr_t'(1);
			end
			default: ;
		endcase
	end

	//----------------------------------------------------------------------
	// read pointers
	//----------------------------------------------------------------------

	// outside a job both pointers rest on word 0 so the headers
	// are already on the read bus when the next job is accepted
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			a_ptr <= '0;
			b_ptr <= '0;
		end else begin
			case (addr_cmd)
				cmd_start: begin
					a_ptr <= sram_addr_t'(1);
					b_ptr <= sram_addr_t'(1);
				end
				cmd_next_k: begin
					a_ptr <= a_ptr + 1'b1;
					b_ptr <= b_ptr + b_stride; // down one row of B
				end
				cmd_next_col: begin
					a_ptr <= a_base;
					b_ptr <= b_col + 1'b1;
				end
				cmd_next_row: begin
					a_ptr <= a_ptr + 1'b1;
					b_ptr <= sram_addr_t'(1);
				end
				default: begin
					a_ptr <= '0;
					b_ptr <= '0;
				end
			endcase
		end
	end

	// C address steps after the write of the element just closed,
	// which lands 2 cycles after its last issue
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			c_step <= '0;
			c_ptr  <= '0;
		end else begin
			c_step <= {c_step[0], (addr_cmd == cmd_next_col) || (addr_cmd == cmd_next_row)};
			if (addr_cmd == cmd_start)
				c_ptr <= '0;
			else if (c_step[1])
				c_ptr <= c_ptr + 1'b1;
		end
	end

endmodule

/* hw/matmul_mac.sv */
// issue alignment stage, 32-bit multiply-accumulate and C write register
`timescale 1ns/1ns

module matmul_mac (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   issue,
	input  logic                   first,
	input  logic                   last,
	input  matmul_pkg::sram_data_t input_read_data,
	input  matmul_pkg::sram_data_t weight_read_data,
	output logic                   result_write_enable,
	output matmul_pkg::sram_data_t result_write_data
);
	import matmul_pkg::*;

	logic       issue_q; // lines up with the read data
	logic       first_q;
	logic       last_q;
	sram_data_t product;
	sram_data_t sum;
	sram_data_t acc;

	assign product = input_read_data * weight_read_data; // low word only, wraps
	assign sum     = first_q ? product : acc + product;

	//----------------------------------------------------------------------
	// control pipeline
	//----------------------------------------------------------------------

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			issue_q             <= 1'b0;
			first_q             <= 1'b0;
			last_q              <= 1'b0;
			result_write_enable <= 1'b0;
		end else begin
			issue_q             <= issue;
			first_q             <= first;
			last_q              <= last;
			result_write_enable <= issue_q && last_q; // one cycle per element
		end
	end

	// running sum, reloaded on the first term of each element
	always_ff @(posedge clk) begin
		if (issue_q)
			acc <= sum;
	end

	always_ff @(posedge clk) begin
		if (issue_q && last_q)
			result_write_data <= sum; // full dot product incl. this term
	end

endmodule

/* hw/matmul_top.sv */
// matrix multiplier top level, controller, address generator and MAC wiring
`timescale 1ns/1ns

module matmul_top (
	input  logic                   clk,
	input  logic                   reset_n,
	input  logic                   dut_valid,
	output logic                   dut_ready,

	// input SRAM, matrix A
	output matmul_pkg::sram_addr_t input_read_address,
	input  matmul_pkg::sram_data_t input_read_data,

	// weight SRAM, matrix B
	output matmul_pkg::sram_addr_t weight_read_address,
	input  matmul_pkg::sram_data_t weight_read_data,

	// result SRAM, matrix C
	output logic                   result_write_enable,
	output matmul_pkg::sram_addr_t result_write_address,
	output matmul_pkg::sram_data_t result_write_data
);
	import matmul_pkg::*;

	addr_cmd_e addr_cmd;
	logic      issue;  // product read on the bus this cycle
	logic      first;  // ... and it opens a dot product
	logic      last;   // ... and it closes one

	//----------------------------------------------------------------------
	// job sequencing
	//----------------------------------------------------------------------

	matmul_ctrl u_ctrl (
		.clk              (clk),
		.reset_n          (reset_n),
		.dut_valid        (dut_valid),
		.dut_ready        (dut_ready),
		.input_read_data  (input_read_data),
		.weight_read_data (weight_read_data),
		.addr_cmd         (addr_cmd),
		.issue            (issue),
		.first            (first),
		.last             (last)
	);

	// write address comes out already delayed to line up with the MAC
	matmul_addr_gen u_addr (
		.clk                  (clk),
		.reset_n              (reset_n),
		.addr_cmd             (addr_cmd),
		.weight_read_data     (weight_read_data),
		.input_read_address   (input_read_address),
		.weight_read_address  (weight_read_address),
		.result_write_address (result_write_address)
	);

	//----------------------------------------------------------------------
	// datapath
	//----------------------------------------------------------------------

	matmul_mac u_mac (
		.clk                 (clk),
		.reset_n             (reset_n),
		.issue               (issue),
		.first               (first),
		.last                (last),
		.input_read_data     (input_read_data),
		.weight_read_data    (weight_read_data),
		.result_write_enable (result_write_enable),
		.result_write_data   (result_write_data)
	);

endmodule

/* tests/matmul_chk.sv */
// concurrent assertions on the start handshake and the result write port
`timescale 1ns/1ns

module matmul_chk (
	input logic                   clk,
	input logic                   reset_n,
	input logic                   dut_valid,
	input logic                   dut_ready,
	input logic                   result_write_enable,
	input matmul_pkg::sram_addr_t result_write_address
);
	import matmul_pkg::*;

	sram_addr_t prev_addr;
	logic       seen_write; // this job already wrote a word

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			seen_write <= 1'b0;
			prev_addr  <= '0;
		end else if (dut_valid && dut_ready) begin
			seen_write <= 1'b0;
		end else if (result_write_enable) begin
			seen_write <= 1'b1;
			prev_addr  <= result_write_address;
		end
	end

	// shortest job is header, one product and two drain cycles
	busy_after_accept: assert property (@(posedge clk) disable iff (!reset_n)
		(dut_valid && dut_ready) |=> !dut_ready [*4])
		else $error("dut_ready high during a running job");

	no_write_when_ready: assert property (@(posedge clk) disable iff (!reset_n)
		!(result_write_enable && dut_ready))
		else $error("result write while dut_ready is high");

	first_write_at_zero: assert property (@(posedge clk) disable iff (!reset_n)
		(result_write_enable && !seen_write) |-> (result_write_address == '0))
		else $error("first result write of a job not at address 0");

	write_addr_step: assert property (@(posedge clk) disable iff (!reset_n)
		(result_write_enable && seen_write) |-> (result_write_address == prev_addr + 1'b1))
		else $error("result write address did not step by one");

endmodule

bind matmul_top matmul_chk u_chk (
	.clk                  (clk),
	.reset_n              (reset_n),
	.dut_valid            (dut_valid),
	.dut_ready            (dut_ready),
	.result_write_enable  (result_write_enable),
	.result_write_address (result_write_address)
);

/* tests/matmul_tb.sv */
// testbench for matmul_top with SRAM models, random jobs and a reference model
`timescale 1ns/1ns

module matmul_tb;
	import matmul_pkg::*;

	localparam int MEM_DEPTH   = 64;  // header plus a full 6x6 matrix
	localparam int MAX_ELEMS   = 36;
	localparam int JOB_TIMEOUT = 400; // cycles for the largest job of 216 products

	logic       clk;
	logic       reset_n;
	logic       dut_valid;
	logic       dut_ready;
	sram_addr_t input_read_address;
	sram_data_t input_read_data;
	sram_addr_t weight_read_address;
	sram_data_t weight_read_data;
	logic       result_write_enable;
	sram_addr_t result_write_address;
	sram_data_t result_write_data;

	sram_data_t input_mem  [0:MEM_DEPTH-1];
	sram_data_t weight_mem [0:MEM_DEPTH-1];
	sram_data_t result_mem [0:MEM_DEPTH-1];
	sram_data_t a_elem     [0:MAX_ELEMS-1];
	sram_data_t b_elem     [0:MAX_ELEMS-1];
	sram_data_t exp_c      [0:MAX_ELEMS-1]; // row-major model result

	integer seed;
	int     value_errors;
	int     other_errors;
	int     write_count;  // C words written in the current job
	bit     job_active;
	bit     timed_out;
	string  job_name;

	matmul_top u_dut (
		.clk                  (clk),
		.reset_n              (reset_n),
		.dut_valid            (dut_valid),
		.dut_ready            (dut_ready),
		.input_read_address   (input_read_address),
		.input_read_data      (input_read_data),
		.weight_read_address  (weight_read_address),
		.weight_read_data     (weight_read_data),
		.result_write_enable  (result_write_enable),
		.result_write_address (result_write_address),
		.result_write_data    (result_write_data)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// ------------------------------------------------------------------------
	// SRAM models with read data one cycle after the address
	// ------------------------------------------------------------------------

	always @(posedge clk) begin
		if (input_read_address < MEM_DEPTH)
			input_read_data <= input_mem[input_read_address];
		else
			input_read_data <= 'x;
		if (weight_read_address < MEM_DEPTH)
			weight_read_data <= weight_mem[weight_read_address];
		else
			weight_read_data <= 'x;
	end

	// result SRAM capture and write address check
	always @(posedge clk) begin
		if (reset_n && result_write_enable) begin
			if (!job_active) begin
				$display("result write at address %0d outside a job", result_write_address);
				other_errors++;
			end
			check_addr({job_name, " write address"}, sram_addr_t'(write_count),
				result_write_address);
			if (result_write_address < MEM_DEPTH)
				result_mem[result_write_address] = result_write_data;
			write_count++;
		end
	end

	// ------------------------------------------------------------------------
	// compare tasks
	// ------------------------------------------------------------------------

	task automatic check_word(input string name, input sram_data_t expected,
		input sram_data_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %h, actual %h", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_addr(input string name, input sram_addr_t expected,
		input sram_addr_t actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected %0d, actual %0d", name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_ready(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR %s: expected dut_ready %b, actual %b", name, expected, actual);
			value_errors++;
		end
	endtask

	// unused words differ at every address
	function automatic sram_data_t fill_pattern(input sram_addr_t addr);
		return sram_data_t'({~addr, addr});
	endfunction

	// ------------------------------------------------------------------------
	// bounded waits
	// ------------------------------------------------------------------------

	task automatic wait_ready(input string name, output bit ok);
		int cnt;
		ok = 1'b0;
		for (cnt = 0; cnt < JOB_TIMEOUT && !ok; cnt++) begin
			@(posedge clk);
			if (dut_ready)
				ok = 1'b1;
		end
		if (!ok) begin
			$display("%s: dut_ready did not rise within %0d cycles", name, JOB_TIMEOUT);
			other_errors++;
		end
	endtask

	task automatic wait_accept(input string name, output bit ok);
		int cnt;
		ok = 1'b0;
		for (cnt = 0; cnt < 20 && !ok; cnt++) begin
			@(posedge clk);
			if (dut_valid && dut_ready)
				ok = 1'b1;
		end
		if (!ok) begin
			$display("%s: job was not accepted within 20 cycles", name);
			other_errors++;
		end
	endtask

	// ------------------------------------------------------------------------
	// job setup and reference model
	// ------------------------------------------------------------------------

	task automatic load_job(input int rows, input int inner, input int cols);
		header_u    hdr;
		sram_data_t acc;
		int         i;
		int         r;
		int         c;
		int         k;
		for (i = 0; i < MEM_DEPTH; i++) begin
			input_mem[i]  <= fill_pattern(sram_addr_t'(i));
			weight_mem[i] <= ~fill_pattern(sram_addr_t'(i));
			result_mem[i] = fill_pattern(sram_addr_t'(i)); // no stale C words
		end
		hdr.hdr.rows = dim_t'(rows);
		hdr.hdr.cols = dim_t'(inner);
		input_mem[0] <= hdr.word;
		hdr.hdr.rows = dim_t'(inner);
		hdr.hdr.cols = dim_t'(cols);
		weight_mem[0] <= hdr.word;
		for (i = 0; i < rows * inner; i++) begin
			a_elem[i] = $random(seed);
			input_mem[1 + i] <= a_elem[i];
		end
		for (i = 0; i < inner * cols; i++) begin
			b_elem[i] = $random(seed);
			weight_mem[1 + i] <= b_elem[i];
		end
		// 32-bit wrapping dot products
		for (r = 0; r < rows; r++) begin
			for (c = 0; c < cols; c++) begin
				acc = '0;
				for (k = 0; k < inner; k++)
					acc = acc + a_elem[r * inner + k] * b_elem[k * cols + c];
				exp_c[r * cols + c] = acc;
			end
		end
	endtask

	// called on an edge where dut_ready was seen high
	task automatic run_job(input string name, input int rows, input int inner, input int cols);
		bit ok;
		int i;
		job_name = name;
		load_job(rows, inner, cols);
		dut_valid <= 1'b1;
		wait_accept(name, ok);
		if (!ok) begin
			timed_out = 1'b1;
			return;
		end
		dut_valid   <= 1'b0;
		job_active  = 1'b1;
		write_count = 0;
		@(posedge clk);
		check_ready({name, " busy after accept"}, 1'b0, dut_ready);
		wait_ready(name, ok);
		job_active = 1'b0;
		if (!ok) begin
			timed_out = 1'b1;
			return;
		end
		check_addr({name, " word count"}, sram_addr_t'(rows * cols), sram_addr_t'(write_count));
		for (i = 0; i < rows * cols; i++)
			check_word($sformatf("%s C[%0d]", name, i), exp_c[i], result_mem[i]);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------

	initial begin
		bit ok;
		int j;
		int rows;
		int inner;
		int cols;
		seed             = 3441;
		value_errors     = 0;
		other_errors     = 0;
		write_count      = 0;
		job_active       = 1'b0;
		timed_out        = 1'b0;
		job_name         = "reset";
		reset_n          = 1'b0;
		dut_valid        = 1'b0;
		input_read_data  = '0;
		weight_read_data = '0;

		repeat (10) @(posedge clk);
		check_ready("reset", 1'b0, dut_ready);
		reset_n <= 1'b1;
		wait_ready("reset", ok);
		if (!ok)
			timed_out = 1'b1;
		else
			check_addr("reset write count", '0, sram_addr_t'(write_count));

		if (!timed_out)
			run_job("single", 1, 1, 1);

		// each job starts right on the edge its predecessor finished
		for (j = 0; j < 12 && !timed_out; j++) begin
			rows  = 1 + $unsigned($random(seed)) % 6;
			inner = 1 + $unsigned($random(seed)) % 6;
			cols  = 1 + $unsigned($random(seed)) % 6;
			run_job($sformatf("random_%0d", j), rows, inner, cols);
		end

		if (!timed_out)
			run_job("b2b_large", 6, 6, 6);
		if (!timed_out)
			run_job("b2b_small", 1, 2, 1);
		if (!timed_out)
			run_job("b2b_wide", 2, 1, 6);

		$display("matmul_tb: %0d value errors, %0d other errors", value_errors, other_errors);
		if (value_errors == 0 && other_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

/* flist.f */
+incdir+hw
hw/matmul_pkg.sv
hw/matmul_ctrl.sv
hw/matmul_addr_gen.sv
hw/matmul_mac.sv
hw/matmul_top.sv
tests/matmul_chk.sv
tests/matmul_tb.sv
